//--- files.f
+incdir+src
src/core_pkg.sv
src/pc_unit.sv
src/instr_decode.sv
src/reg_file.sv
src/alu_execute.sv
src/result_select.sv
src/rv_core.sv
sim/tb_rv_core.sv

//--- sim/core_vectors.txt
// columns: pc, instruction word, expected reg_addr, expected reg_data, all hex.
// reg_data is only compared when reg_addr is not zero; branches skip the word at pc+4.
80000000 123450b7 01 12345000 // lui   x1, 0x12345
80000004 00001117 02 80001004 // auipc x2, 0x1
80000008 ffb00193 03 fffffffb // addi  x3, x0, -5
8000000c 0011a213 04 00000001 // slti  x4, x3, 1
80000010 0011b293 05 00000000 // sltiu x5, x3, 1
80000014 0f00c313 06 123450f0 // xori  x6, x1, 0xf0
80000018 0041e393 07 ffffffff // ori   x7, x3, 4
8000001c 7ff17413 08 00000004 // andi  x8, x2, 0x7ff
80000020 00409493 09 23450000 // slli  x9, x1, 4
80000024 01c1d513 0a 0000000f // srli  x10, x3, 28
80000028 4011d593 0b fffffffd // srai  x11, x3, 1
8000002c 00208633 0c 92346004 // add   x12, x1, x2
80000030 402086b3 0d 92343ffc // sub   x13, x1, x2
80000034 00409733 0e 2468a000 // sll   x14, x1, x4
80000038 0041a7b3 0f 00000001 // slt   x15, x3, x4
8000003c 0041b833 10 00000000 // sltu  x16, x3, x4
80000040 0030c8b3 11 edcbaffb // xor   x17, x1, x3
80000044 0041d933 12 7ffffffd // srl   x18, x3, x4
80000048 4041d9b3 13 fffffffd // sra   x19, x3, x4
8000004c 0080ea33 14 12345004 // or    x20, x1, x8
80000050 00d67ab3 15 92342004 // and   x21, x12, x13
80000054 00508013 00 00000000 // addi  x0, x1, 5
80000058 00400b33 16 00000001 // add   x22, x0, x4
8000005c 00f20463 00 00000000 // beq   x4, x15, +8 taken
80000064 01020463 00 00000000 // beq   x4, x16, +8 not taken
80000068 01021463 00 00000000 // bne   x4, x16, +8 taken
80000070 00f21463 00 00000000 // bne   x4, x15, +8 not taken
80000074 0041c463 00 00000000 // blt   x3, x4, +8 taken
8000007c 00324463 00 00000000 // blt   x4, x3, +8 not taken
80000080 00325463 00 00000000 // bge   x4, x3, +8 taken
80000088 0041d463 00 00000000 // bge   x3, x4, +8 not taken
8000008c 00326463 00 00000000 // bltu  x4, x3, +8 taken
80000094 0041e463 00 00000000 // bltu  x3, x4, +8 not taken
80000098 0041f463 00 00000000 // bgeu  x3, x4, +8 taken
800000a0 00327463 00 00000000 // bgeu  x4, x3, +8 not taken
800000a4 01000bef 17 800000a8 // jal   x23, +16
800000b4 005b8c67 18 800000b8 // jalr  x24, 5(x23), bit 0 cleared
800000ac ffcc0c93 19 800000b4 // addi  x25, x24, -4

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_rv_core;

    localparam int CLK_PERIOD  = 8;    // ns.
    localparam int NUM_VECTORS = 38;   // executed instructions in the program.
    localparam int UPDATE_WAIT = 20;   // cycles allowed for update_o to rise.

    logic                        clk_i = 1'b0;
    logic                        rstn_i;
    logic [`CORE_XLEN-1:0]       instr_i;      // word supplied for the current pc.
    logic                        update_o;
    logic [`CORE_XLEN-1:0]       pc_o;
    logic [`CORE_XLEN-1:0]       instr_o;
    logic [`CORE_REG_ADDR_W-1:0] reg_addr_o;
    logic [`CORE_XLEN-1:0]       reg_data_o;

    logic [31:0] vec_pc    [NUM_VECTORS];   // fetch address of each executed line.
    logic [31:0] vec_instr [NUM_VECTORS];   // instruction word at that address.
    logic [31:0] vec_addr  [NUM_VECTORS];   // expected trace rd index.
    logic [31:0] vec_data  [NUM_VECTORS];   // expected trace write-back value.
    int          num_vectors;               // lines actually read.

    rv_core DUT (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .instr_i    (instr_i),
        .update_o   (update_o),
        .pc_o       (pc_o),
        .instr_o    (instr_o),
        .reg_addr_o (reg_addr_o),
        .reg_data_o (reg_data_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;   // 8 ns period.

    ////////////////////
    // reporting
    ////////////////////
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    ////////////////////
    // vector file
    ////////////////////
    task automatic load_vectors();
        int               fd;
        int               code;
        logic             bad_line;
        logic [31:0]      f_pc, f_instr, f_addr, f_data;
        logic [8*160-1:0] rest;   // remainder of a comment line.
        bad_line    = 1'b0;
        num_vectors = 0;
        fd = $fopen("sim/core_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/core_vectors.txt");
            abort_run();
        end else begin
            while (num_vectors < NUM_VECTORS && !$feof(fd) && !bad_line) begin
                code = $fscanf(fd, "%h %h %h %h\n", f_pc, f_instr, f_addr, f_data);
                if (code == 4) begin
                    vec_pc[num_vectors]    = f_pc;
                    vec_instr[num_vectors] = f_instr;
                    vec_addr[num_vectors]  = f_addr;
                    vec_data[num_vectors]  = f_data;
                    num_vectors++;
                end else if (code == 0) begin
                    void'($fgets(rest, fd));   // comments run to the end of the line.
                end else if (code > 0) begin
                    bad_line = 1'b1;           // a line with fewer than four fields.
                end
            end
            $fclose(fd);
            if (bad_line) begin
                $display("vector line %0d has fewer than four hex fields", num_vectors + 1);
                abort_run();
            end else if (num_vectors < NUM_VECTORS) begin
                $display("vector file ends after %0d of %0d instructions",
                         num_vectors, NUM_VECTORS);
                abort_run();
            end
        end
    endtask

    // update_o marks the first retired instruction after reset.
    task automatic await_update();
        int cycles;
        cycles = 0;
        while (update_o !== 1'b1 && cycles < UPDATE_WAIT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (update_o !== 1'b1) begin
            $display("update_o never rose, the core did not leave reset");
            abort_run();
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        int idx;
        rstn_i  = 1'b0;                              // reset from time zero.
        instr_i = '0;
        load_vectors();
        @(negedge clk_i);                            // inside the first reset cycle.
        check_value("pc_o", pc_o, `CORE_RESET_PC);
        check_value("update_o", update_o, 32'd0);
        @(negedge clk_i);
        rstn_i = 1'b1;                               // released after two cycles.
        for (idx = 0; idx < NUM_VECTORS; idx++) begin
            if (idx != 0) begin
                @(negedge clk_i);                    // pc settled after the last edge.
            end
            check_value("update_o", update_o, (idx == 0) ? 32'd0 : 32'd1);
            check_value("pc_o", pc_o, vec_pc[idx]);  // proves fetch order and branches.
            instr_i = vec_instr[idx];
            #(CLK_PERIOD/4);                         // decode and execute are combinational.
            check_value("instr_o", instr_o, vec_instr[idx]);
            check_value("reg_addr_o", reg_addr_o, vec_addr[idx]);
            if (vec_addr[idx] != 0) begin
                // write-back data only means something when a register is written.
                check_value("reg_data_o", reg_data_o, vec_data[idx]);
            end
            if (idx == 0) begin
                await_update();
            end
        end
        @(posedge clk_i);                            // last instruction retires.
        #1;
        check_value("pc_o", pc_o, vec_pc[NUM_VECTORS-1] + 32'd4);
        check_value("update_o", update_o, 32'd1);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- src/alu_execute.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module alu_execute (
    input  logic [`CORE_XLEN-1:0]  pc_i,
    input  logic [`CORE_XLEN-1:0]  rs1_data_i,
    input  logic [`CORE_XLEN-1:0]  rs2_data_i,
    input  logic [`CORE_XLEN-1:0]  imm_i,
    input  core_pkg::alu_op_e      alu_op_i,
    input  logic                   use_imm_i,
    input  core_pkg::br_op_e       br_op_i,
    input  logic                   target_from_rs1_i,
    output logic                   redirect_o,     // next pc comes from target_o.
    output logic [`CORE_XLEN-1:0]  target_o,
    output logic [`CORE_XLEN-1:0]  alu_result_o
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] op_b;         // second alu operand.
    logic [4:0]            shamt;        // only the low five bits shift.
    logic [`CORE_XLEN-1:0] target_base;  // pc for jal, branches and auipc.
    logic [`CORE_XLEN-1:0] target_sum;   // base plus immediate before alignment.

    assign op_b        = use_imm_i ? imm_i : rs2_data_i;
    assign shamt       = op_b[4:0];
    assign target_base = target_from_rs1_i ? rs1_data_i : pc_i;
    assign target_sum  = target_base + imm_i;
    assign target_o    = {target_sum[`CORE_XLEN-1:1], 1'b0};   // jalr drops bit 0.

    ////////////////////
    // alu
    ////////////////////
    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_result_o = rs1_data_i + op_b;
            ALU_SUB:    alu_result_o = rs1_data_i - op_b;
            ALU_SLL:    alu_result_o = rs1_data_i << shamt;
            ALU_SLT:    alu_result_o = {{(`CORE_XLEN-1){1'b0}},
                                        $signed(rs1_data_i) < $signed(op_b)};
            ALU_SLTU:   alu_result_o = {{(`CORE_XLEN-1){1'b0}}, rs1_data_i < op_b};
            ALU_XOR:    alu_result_o = rs1_data_i ^ op_b;
            ALU_SRL:    alu_result_o = rs1_data_i >> shamt;
            ALU_SRA:    alu_result_o = $unsigned($signed(rs1_data_i) >>> shamt);
            ALU_OR:     alu_result_o = rs1_data_i | op_b;
            ALU_AND:    alu_result_o = rs1_data_i & op_b;
            ALU_PASS_B: alu_result_o = target_sum;     // auipc shares the target adder.
            default:    alu_result_o = '0;
        endcase
    end

    ////////////////////
    // branch comparator
    ////////////////////
    always_comb begin
        case (br_op_i)
            BR_EQ:     redirect_o = rs1_data_i == rs2_data_i;
            BR_NE:     redirect_o = rs1_data_i != rs2_data_i;
            BR_LT:     redirect_o = $signed(rs1_data_i) <  $signed(rs2_data_i);
            BR_GE:     redirect_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
            BR_LTU:    redirect_o = rs1_data_i <  rs2_data_i;
            BR_GEU:    redirect_o = rs1_data_i >= rs2_data_i;
            BR_ALWAYS: redirect_o = 1'b1;              // jumps always leave the sequence.
            default:   redirect_o = 1'b0;              // no control transfer.
        endcase
    end

endmodule

//--- src/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

////////////////////
// architectural widths
////////////////////
`define CORE_XLEN        32              // datapath and pc width in bits.
`define CORE_RESET_PC    32'h8000_0000   // first fetch address after reset.
`define CORE_REG_ADDR_W  5               // index width of the integer register file.
`define CORE_NUM_REGS    32              // number of integer registers, x0 included.

////////////////////
// major opcodes
////////////////////
`define CORE_OP_LUI      7'b0110111      // load upper immediate.
`define CORE_OP_AUIPC    7'b0010111      // add upper immediate to pc.
`define CORE_OP_JAL      7'b1101111      // jump and link, pc relative.
`define CORE_OP_JALR     7'b1100111      // jump and link, register base.
`define CORE_OP_BRANCH   7'b1100011      // conditional branches.
`define CORE_OP_IMM      7'b0010011      // register-immediate arithmetic.
`define CORE_OP_REG      7'b0110011      // register-register arithmetic.

////////////////////
// funct3 and funct7
////////////////////
`define CORE_F3_ADD_SUB  3'b000          // add, sub and addi.
`define CORE_F3_SLL      3'b001          // shift left logical.
`define CORE_F3_SLT      3'b010          // set less than, signed.
`define CORE_F3_SLTU     3'b011          // set less than, unsigned.
`define CORE_F3_XOR      3'b100          // bitwise xor.
`define CORE_F3_SRL_SRA  3'b101          // right shifts, funct7 picks the kind.
`define CORE_F3_OR       3'b110          // bitwise or.
`define CORE_F3_AND      3'b111          // bitwise and.
`define CORE_F3_JALR     3'b000          // the only legal funct3 of jalr.
`define CORE_F3_BEQ      3'b000          // branch if equal.
`define CORE_F3_BNE      3'b001          // branch if not equal.
`define CORE_F3_BLT      3'b100          // branch if less, signed.
`define CORE_F3_BGE      3'b101          // branch if greater or equal, signed.
`define CORE_F3_BLTU     3'b110          // branch if less, unsigned.
`define CORE_F3_BGEU     3'b111          // branch if greater or equal, unsigned.
`define CORE_F7_BASE     7'b0000000      // plain form of an operation.
`define CORE_F7_ALT      7'b0100000      // sub and arithmetic right shift.

`endif

//--- src/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    ////////////////////
    // instruction formats
    ////////////////////
    typedef struct packed {
        logic [6:0]                  funct7;   // selects the alternate operation.
        logic [`CORE_REG_ADDR_W-1:0] rs2;      // second source register.
        logic [`CORE_REG_ADDR_W-1:0] rs1;      // first source register.
        logic [2:0]                  funct3;   // operation within the opcode.
        logic [`CORE_REG_ADDR_W-1:0] rd;       // destination register.
        logic [6:0]                  opcode;   // major opcode.
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                 imm;      // signed 12 bit immediate.
        logic [`CORE_REG_ADDR_W-1:0] rs1;      // base or source register.
        logic [2:0]                  funct3;   // operation within the opcode.
        logic [`CORE_REG_ADDR_W-1:0] rd;       // destination register.
        logic [6:0]                  opcode;   // major opcode.
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                  imm_11_5; // upper immediate bits.
        logic [`CORE_REG_ADDR_W-1:0] rs2;      // data register.
        logic [`CORE_REG_ADDR_W-1:0] rs1;      // base register.
        logic [2:0]                  funct3;   // access size.
        logic [4:0]                  imm_4_0;  // lower immediate bits.
        logic [6:0]                  opcode;   // major opcode.
    } s_fmt_t;

    typedef struct packed {
        logic                        imm_12;   // sign bit of the offset.
        logic [5:0]                  imm_10_5; // offset bits 10 to 5.
        logic [`CORE_REG_ADDR_W-1:0] rs2;      // second compare operand.
        logic [`CORE_REG_ADDR_W-1:0] rs1;      // first compare operand.
        logic [2:0]                  funct3;   // branch condition.
        logic [3:0]                  imm_4_1;  // offset bits 4 to 1.
        logic                        imm_11;   // offset bit 11.
        logic [6:0]                  opcode;   // major opcode.
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]                 imm_31_12; // upper 20 bits of the result.
        logic [`CORE_REG_ADDR_W-1:0] rd;        // destination register.
        logic [6:0]                  opcode;    // major opcode.
    } u_fmt_t;

    typedef struct packed {
        logic                        imm_20;    // sign bit of the offset.
        logic [9:0]                  imm_10_1;  // offset bits 10 to 1.
        logic                        imm_11;    // offset bit 11.
        logic [7:0]                  imm_19_12; // offset bits 19 to 12.
        logic [`CORE_REG_ADDR_W-1:0] rd;        // link register.
        logic [6:0]                  opcode;    // major opcode.
    } j_fmt_t;

    // one fetched word seen through every format at once.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_u;

    ////////////////////
    // control encodings
    ////////////////////
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B                              // passes the pc-relative sum, for auipc.
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
        BR_ALWAYS                               // jal and jalr.
    } br_op_e;

    typedef enum logic [1:0] {
        WB_ALU,                                 // result of the alu.
        WB_PC_PLUS4                             // link address of a jump.
    } wb_sel_e;

endpackage

//--- src/instr_decode.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_decode (
    input  core_pkg::rv_instr_u          instr_i,
    output logic [`CORE_REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`CORE_REG_ADDR_W-1:0]  rs2_addr_o,
    output logic [`CORE_REG_ADDR_W-1:0]  rd_addr_o,
    output logic [`CORE_XLEN-1:0]        imm_o,
    output core_pkg::alu_op_e            alu_op_o,
    output logic                         use_imm_o,          // operand b is the immediate.
    output core_pkg::br_op_e             br_op_o,
    output logic                         target_from_rs1_o,  // jalr takes rs1 as the base.
    output core_pkg::wb_sel_e            wb_sel_o,
    output logic                         rd_we_o
);

    import core_pkg::*;

    logic [6:0]            opcode;               // major opcode of the word.
    logic [2:0]            funct3;               // minor operation code.
    logic [6:0]            funct7;               // alternate operation select.
    logic [`CORE_XLEN-1:0] imm_i_type;           // sign-extended i immediate.
    logic [`CORE_XLEN-1:0] imm_b_type;           // branch offset, bit 0 always zero.
    logic [`CORE_XLEN-1:0] imm_u_type;           // upper immediate with zero low half.
    logic [`CORE_XLEN-1:0] imm_j_type;           // jump offset, bit 0 always zero.
    logic [`CORE_XLEN-1:0] imm_shamt;            // shift amount of slli, srli, srai.

    // plain operation for a funct3, shared by op and op-imm.
    function automatic alu_op_e base_alu_op(input logic [2:0] f3);
        case (f3)
            `CORE_F3_ADD_SUB: return ALU_ADD;
            `CORE_F3_SLL:     return ALU_SLL;
            `CORE_F3_SLT:     return ALU_SLT;
            `CORE_F3_SLTU:    return ALU_SLTU;
            `CORE_F3_XOR:     return ALU_XOR;
            `CORE_F3_SRL_SRA: return ALU_SRL;
            `CORE_F3_OR:      return ALU_OR;
            default:          return ALU_AND;
        endcase
    endfunction

    ////////////////////
    // fields and immediates
    ////////////////////
    assign opcode = instr_i.r_fmt.opcode;
    assign funct3 = instr_i.r_fmt.funct3;
    assign funct7 = instr_i.r_fmt.funct7;

    assign imm_i_type = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
    assign imm_b_type = {{20{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_11,
                         instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};
    assign imm_u_type = {instr_i.u_fmt.imm_31_12, 12'b0};
    assign imm_j_type = {{12{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_19_12,
                         instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_10_1, 1'b0};
    assign imm_shamt  = {{(`CORE_XLEN-`CORE_REG_ADDR_W){1'b0}}, instr_i.r_fmt.rs2};

    // lui reads x0 so that its add yields the bare immediate.
    assign rs1_addr_o = (opcode == `CORE_OP_LUI) ? '0 : instr_i.r_fmt.rs1;
    assign rs2_addr_o = instr_i.r_fmt.rs2;
    assign rd_addr_o  = instr_i.u_fmt.rd;

    ////////////////////
    // operation classification
    ////////////////////
    always_comb begin
        imm_o             = imm_i_type;          // the most common format.
        alu_op_o          = ALU_ADD;
        use_imm_o         = 1'b0;
        br_op_o           = BR_NONE;             // unknown words never redirect.
        target_from_rs1_o = 1'b0;
        wb_sel_o          = WB_ALU;
        rd_we_o           = 1'b0;                // unknown words retire as no-ops.
        case (opcode)
            `CORE_OP_LUI: begin
                imm_o     = imm_u_type;
                use_imm_o = 1'b1;                // x0 plus the upper immediate.
                rd_we_o   = 1'b1;
            end
            `CORE_OP_AUIPC: begin
                imm_o     = imm_u_type;
                alu_op_o  = ALU_PASS_B;          // takes the pc plus immediate sum.
                use_imm_o = 1'b1;
                rd_we_o   = 1'b1;
            end
            `CORE_OP_JAL: begin
                imm_o    = imm_j_type;
                br_op_o  = BR_ALWAYS;
                wb_sel_o = WB_PC_PLUS4;          // link register gets the return address.
                rd_we_o  = 1'b1;
            end
            `CORE_OP_JALR: begin
                if (funct3 == `CORE_F3_JALR) begin
                    br_op_o           = BR_ALWAYS;
                    target_from_rs1_o = 1'b1;    // target is rs1 plus offset.
                    wb_sel_o          = WB_PC_PLUS4;
                    rd_we_o           = 1'b1;
                end
            end
            `CORE_OP_BRANCH: begin
                imm_o = imm_b_type;
                case (funct3)
                    `CORE_F3_BEQ:  br_op_o = BR_EQ;
                    `CORE_F3_BNE:  br_op_o = BR_NE;
                    `CORE_F3_BLT:  br_op_o = BR_LT;
                    `CORE_F3_BGE:  br_op_o = BR_GE;
                    `CORE_F3_BLTU: br_op_o = BR_LTU;
                    `CORE_F3_BGEU: br_op_o = BR_GEU;
                    default:       br_op_o = BR_NONE;   // 010 and 011 are reserved.
                endcase
            end
            `CORE_OP_IMM: begin
                alu_op_o  = base_alu_op(funct3);
                use_imm_o = 1'b1;
                rd_we_o   = 1'b1;
                if (funct3 == `CORE_F3_SLL || funct3 == `CORE_F3_SRL_SRA) begin
                    imm_o = imm_shamt;           // shifts carry funct7 in the upper bits.
                    if (funct7 == `CORE_F7_ALT && funct3 == `CORE_F3_SRL_SRA) begin
                        alu_op_o = ALU_SRA;
                    end else if (funct7 != `CORE_F7_BASE) begin
                        rd_we_o = 1'b0;          // illegal shift encoding.
                    end
                end
            end
            `CORE_OP_REG: begin
                alu_op_o = base_alu_op(funct3);
                rd_we_o  = 1'b1;
                if (funct7 == `CORE_F7_ALT && funct3 == `CORE_F3_ADD_SUB) begin
                    alu_op_o = ALU_SUB;
                end else if (funct7 == `CORE_F7_ALT && funct3 == `CORE_F3_SRL_SRA) begin
                    alu_op_o = ALU_SRA;
                end else if (funct7 != `CORE_F7_BASE) begin
                    rd_we_o = 1'b0;              // no other funct7 is defined in rv32i.
                end
            end
            default: ;
        endcase
    end

endmodule

//--- src/pc_unit.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module pc_unit (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  redirect_i,   // a jump or a taken branch this cycle.
    input  logic [`CORE_XLEN-1:0] target_i,     // where the redirect goes.
    output logic [`CORE_XLEN-1:0] pc_o,         // address of the instruction in flight.
    output logic                  update_o      // set once the first instruction retired.
);

    logic [`CORE_XLEN-1:0] pc_next;             // address of the following instruction.

    // sequential flow unless execute asks for a redirect.
    assign pc_next = redirect_i ? target_i : pc_o + `CORE_XLEN'(4);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_o     <= `CORE_RESET_PC;         // fetch restarts at the boot address.
            update_o <= 1'b0;                   // nothing has retired yet.
        end else begin
            pc_o     <= pc_next;                // one instruction completes every cycle.
            update_o <= 1'b1;                   // stays high from here on.
        end
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic [`CORE_REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [`CORE_REG_ADDR_W-1:0]  rs2_addr_i,
    input  logic [`CORE_REG_ADDR_W-1:0]  rd_addr_i,
    input  logic                         rd_we_i,
    input  logic [`CORE_XLEN-1:0]        rd_data_i,
    output logic [`CORE_XLEN-1:0]        rs1_data_o,
    output logic [`CORE_XLEN-1:0]        rs2_data_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];   // x0 stays at its reset value of zero.

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;                      // architectural state starts cleared.
            end
        end else if (rd_we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;           // writes to x0 are dropped.
        end
    end

    // reads are combinational, so a value written last cycle is visible now.
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

//--- src/result_select.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module result_select (
    input  logic [`CORE_XLEN-1:0]        pc_i,
    input  logic [`CORE_XLEN-1:0]        alu_result_i,
    input  core_pkg::wb_sel_e            wb_sel_i,
    input  logic                         rd_we_i,
    input  logic [`CORE_REG_ADDR_W-1:0]  rd_addr_i,
    output logic                         rd_we_o,      // write port of the register file.
    output logic [`CORE_REG_ADDR_W-1:0]  rd_addr_o,
    output logic [`CORE_XLEN-1:0]        rd_data_o,
    output logic [`CORE_REG_ADDR_W-1:0]  reg_addr_o,   // retire trace.
    output logic [`CORE_XLEN-1:0]        reg_data_o
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] wb_data;   // value headed for rd.

    always_comb begin
        case (wb_sel_i)
            WB_PC_PLUS4: wb_data = pc_i + `CORE_XLEN'(4);   // return address of a jump.
            default:     wb_data = alu_result_i;
        endcase
    end

    assign rd_we_o   = rd_we_i;
    assign rd_addr_o = rd_addr_i;
    assign rd_data_o = wb_data;

    // the trace reports rd only for writing instructions, x0 included.
    assign reg_addr_o = rd_we_i ? rd_addr_i : '0;
    assign reg_data_o = wb_data;

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module rv_core (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic [`CORE_XLEN-1:0]        instr_i,      // word at pc_o from program memory.
    output logic                         update_o,
    output logic [`CORE_XLEN-1:0]        pc_o,
    output logic [`CORE_XLEN-1:0]        instr_o,
    output logic [`CORE_REG_ADDR_W-1:0]  reg_addr_o,
    output logic [`CORE_XLEN-1:0]        reg_data_o
);

    import core_pkg::*;

    logic [`CORE_REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;   // register indices.
    logic [`CORE_REG_ADDR_W-1:0] wr_addr;                       // write port index.
    logic [`CORE_XLEN-1:0]       rs1_data, rs2_data, imm;
    logic [`CORE_XLEN-1:0]       alu_result, target, wr_data;
    alu_op_e                     alu_op;
    br_op_e                      br_op;
    wb_sel_e                     wb_sel;
    logic                        use_imm, target_from_rs1;
    logic                        rd_we, wr_en, redirect;

    assign instr_o = instr_i;   // the trace echoes the fetched word.

    ////////////////////
    // datapath
    ////////////////////
    pc_unit u_pc_unit (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .redirect_i (redirect),
        .target_i   (target),
        .pc_o       (pc_o),
        .update_o   (update_o)
    );

    instr_decode u_instr_decode (
        .instr_i           (instr_i),
        .rs1_addr_o        (rs1_addr),
        .rs2_addr_o        (rs2_addr),
        .rd_addr_o         (rd_addr),
        .imm_o             (imm),
        .alu_op_o          (alu_op),
        .use_imm_o         (use_imm),
        .br_op_o           (br_op),
        .target_from_rs1_o (target_from_rs1),
        .wb_sel_o          (wb_sel),
        .rd_we_o           (rd_we)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (wr_addr),
        .rd_we_i    (wr_en),
        .rd_data_i  (wr_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu_execute u_alu_execute (
        .pc_i              (pc_o),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .imm_i             (imm),
        .alu_op_i          (alu_op),
        .use_imm_i         (use_imm),
        .br_op_i           (br_op),
        .target_from_rs1_i (target_from_rs1),
        .redirect_o        (redirect),
        .target_o          (target),
        .alu_result_o      (alu_result)
    );

    result_select u_result_select (
        .pc_i         (pc_o),
        .alu_result_i (alu_result),
        .wb_sel_i     (wb_sel),
        .rd_we_i      (rd_we),
        .rd_addr_i    (rd_addr),
        .rd_we_o      (wr_en),
        .rd_addr_o    (wr_addr),
        .rd_data_o    (wr_data),
        .reg_addr_o   (reg_addr_o),
        .reg_data_o   (reg_data_o)
    );

endmodule
